// ==== rtl/periph_pkg.sv ====
// Shared types and address map for the peripheral subsystem.
// Byte addresses are 16 bits. Bits 15:12 select a slave page and
// bits 5:2 select a word register inside it. Bits 11:6 and 1:0 are ignored.
// Only full 32-bit word accesses exist. There are no byte lanes.

package periph_pkg;

   //************************************************************
   // Vector types
   //************************************************************
   typedef logic [15:0] addr_t;
   typedef logic [31:0] data_t;
   typedef logic [3:0]  page_t;
   typedef logic [3:0]  reg_idx_t;
   typedef logic [31:0] gpio_t;

   //************************************************************
   // Address map
   //************************************************************
   localparam page_t PAGE_SYSCON = 4'd0;
   localparam page_t PAGE_GPIO   = 4'd1;

   localparam data_t SYSCON_VERSION = 32'h5045_0100;

   // System controller registers
   localparam reg_idx_t SYS_VERSION  = 4'd0;
   localparam reg_idx_t SYS_MTIME    = 4'd1;
   localparam reg_idx_t SYS_MTIMECMP = 4'd2;
   localparam reg_idx_t SYS_SW_IRQ   = 4'd3;
   localparam reg_idx_t SYS_IRQ_STAT = 4'd4;

   // GPIO registers
   localparam reg_idx_t GPIO_IN       = 4'd0;
   localparam reg_idx_t GPIO_OUT      = 4'd1;
   localparam reg_idx_t GPIO_OE       = 4'd2;
   localparam reg_idx_t GPIO_IRQ_MASK = 4'd3;
   localparam reg_idx_t GPIO_IRQ_STAT = 4'd4;

   //************************************************************
   // Bus and interrupt structs
   //************************************************************
   typedef struct packed {
      addr_t addr;
      data_t wdata;
      logic  we;
   } bus_req_t;

   typedef struct packed {
      data_t rdata;
      logic  err;
   } bus_rsp_t;

   typedef struct packed {
      reg_idx_t idx;
      data_t    wdata;
      logic     we;
   } pbus_req_t;

   // Timer lands in bit 0, sw4 sits above sw3 as on the core side
   typedef struct packed {
      logic gpio;
      logic sw4;
      logic sw3;
      logic timer;
   } irq_vec_t;

   typedef enum logic [1:0] {
      IDLE,
      ACCESS,
      RESPOND
   } bridge_state_t;

endpackage

// ==== rtl/mtime_counter.sv ====
// Free-running 32-bit machine timer.
// The counter wraps silently at all ones.
// The timer interrupt is a registered compare, so it trails the
// counter by one cycle and stays high while mtime >= mtimecmp.

module mtime_counter (
   input  logic              i_clk,
   input  logic              i_rst_n,
   input  periph_pkg::data_t i_mtimecmp,
   output periph_pkg::data_t o_mtime,
   output logic              o_timer_irq
);

   //************************************************************
   // Cycle counter
   //************************************************************
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         o_mtime <= '0;
      end else begin
         o_mtime <= o_mtime + 32'd1;
      end
   end

   //************************************************************
   // Compare
   //************************************************************
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         o_timer_irq <= 1'b0;
      end else begin
         o_timer_irq <= (o_mtime >= i_mtimecmp);
      end
   end

endmodule

// ==== rtl/syscon_regs.sv ====
// System controller slave on the peripheral bus.
// Holds version, machine timer, timer compare and two software interrupts.
// The compare register resets to all ones so the timer stays quiet.
// Interrupt status is read only. Unused offsets read as zero and
// ignore writes.

module syscon_regs (
   input  logic                  i_clk,
   input  logic                  i_rst_n,
   input  periph_pkg::pbus_req_t i_pbus,
   input  logic                  i_stb,
   output logic                  o_ack,
   output periph_pkg::data_t     o_rdata,
   output logic                  o_timer_irq,
   output logic                  o_sw_irq3,
   output logic                  o_sw_irq4
);
   import periph_pkg::*;

   data_t       mtime;
   data_t       mtimecmp;
   logic [1:0]  sw_irq;
   logic        wr_en;
   data_t       rd_mux;

   // First strobe cycle only
   assign wr_en = i_stb & ~o_ack & i_pbus.we;

   mtime_counter mtime_counter_i (
      .i_clk       (i_clk),
      .i_rst_n     (i_rst_n),
      .i_mtimecmp  (mtimecmp),
      .o_mtime     (mtime),
      .o_timer_irq (o_timer_irq)
   );

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         mtimecmp <= '1;
         sw_irq   <= 2'b00;
      end else if (wr_en) begin
         if (i_pbus.idx == SYS_MTIMECMP) mtimecmp <= i_pbus.wdata;
         if (i_pbus.idx == SYS_SW_IRQ)   sw_irq   <= i_pbus.wdata[1:0];
      end
   end

   always_comb begin
      case (i_pbus.idx)
         SYS_VERSION:  rd_mux = SYSCON_VERSION;
         SYS_MTIME:    rd_mux = mtime;
         SYS_MTIMECMP: rd_mux = mtimecmp;
         SYS_SW_IRQ:   rd_mux = {30'd0, sw_irq};
         SYS_IRQ_STAT: rd_mux = {29'd0, sw_irq[1], sw_irq[0], o_timer_irq};
         default:      rd_mux = '0;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) o_ack <= 1'b0;
      else          o_ack <= i_stb & ~o_ack;
   end

   always_ff @(posedge i_clk) begin
      if (i_stb && !o_ack) o_rdata <= rd_mux;
   end

   assign o_sw_irq3 = sw_irq[0];
   assign o_sw_irq4 = sw_irq[1];

endmodule

// ==== rtl/gpio_regs.sv ====
// 32-pin GPIO slave on the peripheral bus.
// Pins pass a two-flop synchronizer and show in GPIO_IN two cycles later.
// Any edge on a masked pin sets its status bit one cycle after that.
// Status bits clear by writing ones; a change in the same cycle wins.
// Output enable is only reported. The pads sit outside this block.

module gpio_regs (
   input  logic                  i_clk,
   input  logic                  i_rst_n,
   input  periph_pkg::pbus_req_t i_pbus,
   input  logic                  i_stb,
   output logic                  o_ack,
   output periph_pkg::data_t     o_rdata,
   input  periph_pkg::gpio_t     i_gpio_in,
   output periph_pkg::gpio_t     o_gpio_out,
   output periph_pkg::gpio_t     o_gpio_oe,
   output logic                  o_irq
);
   import periph_pkg::*;

   gpio_t sync1;
   gpio_t sync2;
   gpio_t prev;
   gpio_t change;
   gpio_t irq_mask;
   gpio_t irq_stat;
   gpio_t stat_clr;
   logic  wr_en;
   data_t rd_mux;

   assign wr_en    = i_stb & ~o_ack & i_pbus.we;
   assign change   = sync2 ^ prev;
   assign stat_clr = (wr_en && i_pbus.idx == GPIO_IRQ_STAT) ? i_pbus.wdata : '0;

   //************************************************************
   // Input synchronizer and change detect
   //************************************************************
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         sync1    <= '0;
         sync2    <= '0;
         prev     <= '0;
         irq_stat <= '0;
      end else begin
         sync1    <= i_gpio_in;
         sync2    <= sync1;
         prev     <= sync2;
         irq_stat <= (irq_stat & ~stat_clr) | (change & irq_mask);
      end
   end

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         o_gpio_out <= '0;
         o_gpio_oe  <= '0;
         irq_mask   <= '0;
      end else if (wr_en) begin
         case (i_pbus.idx)
            GPIO_OUT:      o_gpio_out <= i_pbus.wdata;
            GPIO_OE:       o_gpio_oe  <= i_pbus.wdata;
            GPIO_IRQ_MASK: irq_mask   <= i_pbus.wdata;
            default: ;
         endcase
      end
   end

   always_comb begin
      case (i_pbus.idx)
         GPIO_IN:       rd_mux = sync2;
         GPIO_OUT:      rd_mux = o_gpio_out;
         GPIO_OE:       rd_mux = o_gpio_oe;
         GPIO_IRQ_MASK: rd_mux = irq_mask;
         GPIO_IRQ_STAT: rd_mux = irq_stat;
         default:       rd_mux = '0;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) o_ack <= 1'b0;
      else          o_ack <= i_stb & ~o_ack;
   end

   always_ff @(posedge i_clk) begin
      if (i_stb && !o_ack) o_rdata <= rd_mux;
   end

   assign o_irq = |irq_stat;

   a_ack_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      o_ack |=> !o_ack)
      else $error("gpio ack held for two cycles");

endmodule

// ==== rtl/bus_bridge_fsm.sv ====
// Request/response bridge onto the internal peripheral bus.
// One request is in flight at a time. Ready is high only while idle.
// Mapped pages answer three edges after the request transfer.
// Unmapped pages answer on the next edge with err set and zero data.
// Slaves must ack for exactly one cycle, one cycle after the strobe.

module bus_bridge_fsm (
   input  logic                  i_clk,
   input  logic                  i_rst_n,
   input  logic                  i_req_valid,
   output logic                  o_req_ready,
   input  periph_pkg::bus_req_t  i_req,
   output logic                  o_rsp_valid,
   input  logic                  i_rsp_ready,
   output periph_pkg::bus_rsp_t  o_rsp,
   output periph_pkg::pbus_req_t o_pbus,
   output logic                  o_sys_stb,
   output logic                  o_gpio_stb,
   input  logic                  i_sys_ack,
   input  periph_pkg::data_t     i_sys_rdata,
   input  logic                  i_gpio_ack,
   input  periph_pkg::data_t     i_gpio_rdata
);
   import periph_pkg::*;

   bridge_state_t state;
   page_t         req_page;
   logic          req_mapped;
   logic          sel_sys;
   logic          sel_gpio;
   logic          slv_ack;
   data_t         slv_rdata;
   pbus_req_t     pbus_q;
   bus_rsp_t      rsp_q;

   assign req_page   = i_req.addr[15:12];
   assign req_mapped = (req_page == PAGE_SYSCON) || (req_page == PAGE_GPIO);

   assign slv_ack   = (sel_sys & i_sys_ack) | (sel_gpio & i_gpio_ack);
   assign slv_rdata = sel_sys ? i_sys_rdata : i_gpio_rdata;

   //************************************************************
   // Control FSM
   //************************************************************
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         state    <= IDLE;
         sel_sys  <= 1'b0;
         sel_gpio <= 1'b0;
      end else begin
         case (state)
            IDLE: begin
               if (i_req_valid) begin
                  sel_sys  <= (req_page == PAGE_SYSCON);
                  sel_gpio <= (req_page == PAGE_GPIO);
                  state    <= req_mapped ? ACCESS : RESPOND;
               end
            end
            ACCESS: begin
               if (slv_ack) begin
                  state <= RESPOND;
               end
            end
            RESPOND: begin
               if (i_rsp_ready) begin
                  state <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // Held request and response payload
   always_ff @(posedge i_clk) begin
      if (state == IDLE && i_req_valid) begin
         pbus_q.idx   <= i_req.addr[5:2];
         pbus_q.wdata <= i_req.wdata;
         pbus_q.we    <= i_req.we;
         rsp_q.rdata  <= '0;
         rsp_q.err    <= !req_mapped;
      end else if (state == ACCESS && slv_ack) begin
         rsp_q.rdata <= slv_rdata;
         rsp_q.err   <= 1'b0;
      end
   end

   assign o_req_ready = (state == IDLE);
   assign o_rsp_valid = (state == RESPOND);
   assign o_rsp       = rsp_q;
   assign o_pbus      = pbus_q;
   assign o_sys_stb   = (state == ACCESS) & sel_sys;
   assign o_gpio_stb  = (state == ACCESS) & sel_gpio;

   a_one_strobe: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      !(o_sys_stb && o_gpio_stb))
      else $error("both peripheral strobes high");

   // Back-pressure keeps the response intact
   a_rsp_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      (o_rsp_valid && !i_rsp_ready) |=> (o_rsp_valid && $stable(o_rsp)))
      else $error("response changed while stalled");

endmodule

// ==== rtl/periph_top.sv ====
// Peripheral subsystem top level: bridge, system controller and GPIO.
// Pins come out as separate input, output and output-enable vectors.
// All four interrupt lines leave on o_irq.

module periph_top (
   input  logic                 i_clk,
   input  logic                 i_rst_n,
   input  logic                 i_req_valid,
   output logic                 o_req_ready,
   input  periph_pkg::bus_req_t i_req,
   output logic                 o_rsp_valid,
   input  logic                 i_rsp_ready,
   output periph_pkg::bus_rsp_t o_rsp,
   input  periph_pkg::gpio_t    i_gpio_in,
   output periph_pkg::gpio_t    o_gpio_out,
   output periph_pkg::gpio_t    o_gpio_oe,
   output periph_pkg::irq_vec_t o_irq
);
   import periph_pkg::*;

   pbus_req_t pbus;
   logic      sys_stb, sys_ack;
   logic      gpio_stb, gpio_ack;
   data_t     sys_rdata, gpio_rdata;
   logic      timer_irq, sw_irq3, sw_irq4, gpio_irq;

   bus_bridge_fsm bus_bridge_fsm_i (
      .i_clk (i_clk), .i_rst_n (i_rst_n),
      .i_req_valid (i_req_valid), .o_req_ready (o_req_ready), .i_req (i_req),
      .o_rsp_valid (o_rsp_valid), .i_rsp_ready (i_rsp_ready), .o_rsp (o_rsp),
      .o_pbus (pbus), .o_sys_stb (sys_stb), .o_gpio_stb (gpio_stb),
      .i_sys_ack (sys_ack), .i_sys_rdata (sys_rdata),
      .i_gpio_ack (gpio_ack), .i_gpio_rdata (gpio_rdata)
   );

   syscon_regs syscon_regs_i (
      .i_clk (i_clk), .i_rst_n (i_rst_n), .i_pbus (pbus), .i_stb (sys_stb),
      .o_ack (sys_ack), .o_rdata (sys_rdata), .o_timer_irq (timer_irq),
      .o_sw_irq3 (sw_irq3), .o_sw_irq4 (sw_irq4)
   );

   gpio_regs gpio_regs_i (
      .i_clk (i_clk), .i_rst_n (i_rst_n), .i_pbus (pbus), .i_stb (gpio_stb),
      .o_ack (gpio_ack), .o_rdata (gpio_rdata), .i_gpio_in (i_gpio_in),
      .o_gpio_out (o_gpio_out), .o_gpio_oe (o_gpio_oe), .o_irq (gpio_irq)
   );

   assign o_irq.timer = timer_irq;
   assign o_irq.sw3   = sw_irq3;
   assign o_irq.sw4   = sw_irq4;
   assign o_irq.gpio  = gpio_irq;

endmodule

// ==== dv/tb_clk_gen.sv ====
// Testbench clock and reset source.
// Clock period is 10 time units. Reset is held low for 5 rising edges
// and released just after the fifth edge, matching the synchronous reset.

module tb_clk_gen (
   output logic o_clk,
   output logic o_rst_n
);

   initial begin
      o_clk = 1'b0;
      forever #5 o_clk = ~o_clk;
   end

   initial begin
      o_rst_n = 1'b0;
      repeat (5) @(posedge o_clk);
      #1 o_rst_n = 1'b1;
   end

endmodule

// ==== dv/periph_tb.sv ====
// Testbench for periph_top.
// Inputs change and outputs are sampled 1 time unit after each rising edge.
// Every transfer stalls the response channel for 0 to 7 random cycles.
// Pins only change between bus transfers, so GPIO change bits are exact.

module periph_tb;
   import periph_pkg::*;

   localparam int TIMEOUT = 200;

   logic     clk;
   logic     rst_n;
   logic     req_valid;
   logic     req_ready;
   bus_req_t req;
   logic     rsp_valid;
   logic     rsp_ready;
   bus_rsp_t rsp;
   gpio_t    gpio_in;
   gpio_t    gpio_out;
   gpio_t    gpio_oe;
   irq_vec_t irq;

   integer     seed;
   gpio_t      m_out;
   gpio_t      m_oe;
   gpio_t      m_mask;
   gpio_t      m_stat;
   gpio_t      m_pins;
   logic [1:0] m_sw;

   tb_clk_gen clk_gen_i (.o_clk (clk), .o_rst_n (rst_n));

   periph_top periph_top_i (
      .i_clk (clk), .i_rst_n (rst_n),
      .i_req_valid (req_valid), .o_req_ready (req_ready), .i_req (req),
      .o_rsp_valid (rsp_valid), .i_rsp_ready (rsp_ready), .o_rsp (rsp),
      .i_gpio_in (gpio_in), .o_gpio_out (gpio_out), .o_gpio_oe (gpio_oe),
      .o_irq (irq)
   );

   //************************************************************
   // Helpers and reference model
   //************************************************************
   task automatic abort_run();
      $display("tests failed");
      $fatal(1, "stopped at first failure");
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   function automatic addr_t mk_addr(input page_t page, input reg_idx_t idx);
      return {page, 6'd0, idx, 2'b00};
   endfunction

   function automatic bus_rsp_t mk_rsp(input data_t rdata, input logic err);
      bus_rsp_t r;
      r.rdata = rdata;
      r.err   = err;
      return r;
   endfunction

   function automatic irq_vec_t model_irq(input logic timer);
      irq_vec_t v;
      v.timer = timer;
      v.sw3   = m_sw[0];
      v.sw4   = m_sw[1];
      v.gpio  = |m_stat;
      return v;
   endfunction

   task automatic check_rsp(input bus_rsp_t got, input bus_rsp_t exp, input string what);
      if (got !== exp) begin
         $display("ERROR %0t: %s got data %h err %b, expected data %h err %b",
                  $time, what, got.rdata, got.err, exp.rdata, exp.err);
         abort_run();
      end
   endtask

   task automatic check_gpio(input gpio_t got, input gpio_t exp, input string what);
      if (got !== exp) begin
         $display("ERROR %0t: %s got %h, expected %h", $time, what, got, exp);
         abort_run();
      end
   endtask

   task automatic check_irq(input irq_vec_t got, input irq_vec_t exp, input string what);
      if (got !== exp) begin
         $display("ERROR %0t: %s got %b, expected %b", $time, what, got, exp);
         abort_run();
      end
   endtask

   // One request, then a random stall before the response is taken
   task automatic bus_xfer(input addr_t addr, input data_t wdata, input logic we,
                           output bus_rsp_t got);
      int       cnt;
      int       stall;
      bus_rsp_t held;
      req_valid = 1'b1;
      req.addr  = addr;
      req.wdata = wdata;
      req.we    = we;
      cnt = 0;
      while (!req_ready) begin
         next_cycle();
         cnt++;
         if (cnt > TIMEOUT) begin
            $display("The request was never accepted by the DUT");
            abort_run();
         end
      end
      next_cycle();
      req_valid = 1'b0;
      cnt = 0;
      while (!rsp_valid) begin
         next_cycle();
         cnt++;
         if (cnt > TIMEOUT) begin
            $display("No response arrived for an accepted request");
            abort_run();
         end
      end
      held  = rsp;
      stall = {$random(seed)} % 8;
      repeat (stall) begin
         next_cycle();
         if (!rsp_valid || req_ready) begin
            $display("Response valid dropped or request ready rose during a stall");
            abort_run();
         end
         check_rsp(rsp, held, "stalled response");
      end
      rsp_ready = 1'b1;
      next_cycle();
      rsp_ready = 1'b0;
      got = held;
   endtask

   task automatic reg_write(input page_t page, input reg_idx_t idx, input data_t wdata);
      bus_rsp_t got;
      bus_xfer(mk_addr(page, idx), wdata, 1'b1, got);
      if (got.err !== 1'b0) begin
         $display("ERROR %0t: write to page %0d offset %0d flagged an error",
                  $time, page, idx);
         abort_run();
      end
   endtask

   task automatic reg_read_check(input page_t page, input reg_idx_t idx, input data_t exp,
                                 input string what);
      bus_rsp_t got;
      bus_xfer(mk_addr(page, idx), '0, 1'b0, got);
      check_rsp(got, mk_rsp(exp, 1'b0), what);
   endtask

   task automatic wait_timer_irq(input logic level);
      int cnt;
      cnt = 0;
      while (irq.timer !== level) begin
         next_cycle();
         cnt++;
         if (cnt > TIMEOUT) begin
            $display("The timer interrupt never reached the expected level");
            abort_run();
         end
      end
   endtask

   //************************************************************
   // Test sequence
   //************************************************************
   initial begin : main_seq
      bus_rsp_t got;
      data_t    wd;
      data_t    t0;
      gpio_t    pins;
      page_t    bad_page;
      int       cnt;
      seed      = 32'h06bb3802;
      req_valid = 1'b0;
      req       = '0;
      rsp_ready = 1'b0;
      gpio_in   = '0;
      m_out     = '0;
      m_oe      = '0;
      m_mask    = '0;
      m_stat    = '0;
      m_pins    = '0;
      m_sw      = 2'b00;
      cnt = 0;
      while (rst_n !== 1'b1) begin
         next_cycle();
         cnt++;
         if (cnt > TIMEOUT) begin
            $display("Reset was never released");
            abort_run();
         end
      end
      next_cycle();
      check_irq(irq, model_irq(1'b0), "irq after reset");
      check_gpio(gpio_out, '0, "gpio out after reset");
      check_gpio(gpio_oe, '0, "gpio oe after reset");

      // Register writes and readback
      repeat (10) begin
         wd = $random(seed);
         case ({$random(seed)} % 3)
            0: begin
               reg_write(PAGE_GPIO, GPIO_OUT, wd);
               m_out = wd;
            end
            1: begin
               reg_write(PAGE_GPIO, GPIO_OE, wd);
               m_oe = wd;
            end
            default: begin
               reg_write(PAGE_SYSCON, SYS_SW_IRQ, wd);
               m_sw = wd[1:0];
            end
         endcase
         check_gpio(gpio_out, m_out, "gpio out pins");
         check_gpio(gpio_oe, m_oe, "gpio oe pins");
         check_irq(irq, model_irq(1'b0), "software irq lines");
         reg_read_check(PAGE_GPIO, GPIO_OUT, m_out, "GPIO_OUT readback");
         reg_read_check(PAGE_GPIO, GPIO_OE, m_oe, "GPIO_OE readback");
         reg_read_check(PAGE_SYSCON, SYS_SW_IRQ, {30'd0, m_sw}, "SYS_SW_IRQ readback");
      end

      // Version and unmapped pages
      reg_read_check(PAGE_SYSCON, SYS_VERSION, SYSCON_VERSION, "version register");
      repeat (4) begin
         bad_page = 4'd2 + ({$random(seed)} % 14);
         wd = $random(seed);
         bus_xfer(mk_addr(bad_page, GPIO_OUT), wd, 1'b1, got);
         check_rsp(got, mk_rsp('0, 1'b1), "unmapped write");
         bus_xfer(mk_addr(bad_page, SYS_SW_IRQ), wd, 1'b1, got);
         check_rsp(got, mk_rsp('0, 1'b1), "unmapped write");
         bus_xfer(mk_addr(bad_page, GPIO_OE), '0, 1'b0, got);
         check_rsp(got, mk_rsp('0, 1'b1), "unmapped read");
      end
      check_gpio(gpio_out, m_out, "gpio out after unmapped writes");
      reg_read_check(PAGE_GPIO, GPIO_OUT, m_out, "GPIO_OUT after unmapped writes");
      reg_read_check(PAGE_SYSCON, SYS_SW_IRQ, {30'd0, m_sw}, "SW_IRQ after unmapped writes");

      // Machine timer
      reg_write(PAGE_SYSCON, SYS_MTIMECMP, 32'd16);
      wait_timer_irq(1'b1);
      check_irq(irq, model_irq(1'b1), "timer irq raised");
      reg_read_check(PAGE_SYSCON, SYS_IRQ_STAT, {29'd0, m_sw, 1'b1}, "SYS_IRQ_STAT");
      reg_write(PAGE_SYSCON, SYS_MTIMECMP, '1);
      wait_timer_irq(1'b0);
      check_irq(irq, model_irq(1'b0), "timer irq cleared");
      bus_xfer(mk_addr(PAGE_SYSCON, SYS_MTIME), '0, 1'b0, got);
      t0 = got.rdata;
      bus_xfer(mk_addr(PAGE_SYSCON, SYS_MTIME), '0, 1'b0, got);
      if (got.err !== 1'b0 || got.rdata <= t0) begin
         $display("ERROR %0t: mtime read %h after %h", $time, got.rdata, t0);
         abort_run();
      end

      // Pin changes and GPIO change interrupts
      repeat (8) begin
         wd = $random(seed);
         reg_write(PAGE_GPIO, GPIO_IRQ_MASK, wd);
         m_mask = wd;
         pins = $random(seed);
         m_stat = m_stat | ((pins ^ m_pins) & m_mask);
         m_pins = pins;
         gpio_in = pins;
         // Two synchronizer stages plus the status flop
         repeat (4) next_cycle();
         reg_read_check(PAGE_GPIO, GPIO_IN, m_pins, "GPIO_IN pins");
         reg_read_check(PAGE_GPIO, GPIO_IRQ_STAT, m_stat, "GPIO_IRQ_STAT");
         check_irq(irq, model_irq(1'b0), "gpio irq line");
         reg_write(PAGE_GPIO, GPIO_IRQ_STAT, m_stat);
         m_stat = '0;
         reg_read_check(PAGE_GPIO, GPIO_IRQ_STAT, m_stat, "GPIO_IRQ_STAT after clear");
         check_irq(irq, model_irq(1'b0), "gpio irq line after clear");
      end

      $display("all tests passed");
      $finish;
   end

endmodule

// ==== all.f ====
rtl/periph_pkg.sv
rtl/mtime_counter.sv
rtl/syscon_regs.sv
rtl/gpio_regs.sv
rtl/bus_bridge_fsm.sv
rtl/periph_top.sv
dv/tb_clk_gen.sv
dv/periph_tb.sv
